//--- rtl/ooo_pkg.sv
package ooo_pkg;

    // datapath and tag widths
    localparam int XLEN     = 32;
    localparam int TAG_W    = 6;   // physical register tag

    // reservation station geometry
    localparam int RS_DEPTH = 8;
    localparam int RS_IDX_W = 3;

    // execution unit latency, issue to result valid
    localparam int MUL_STAGES = 3;

    // opcodes carried from dispatch to the units
    // OP_MUL goes to the multiplier, the rest to the alu
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } op_e;

endpackage

//--- rtl/reservation_station.sv
`timescale 1ns/1ps

module reservation_station
    import ooo_pkg::*;
(
    input  logic             rs_on,
    input  logic             rst_n,

    input  logic             disp_valid,
    input  op_e              disp_op,
    input  logic [TAG_W-1:0] disp_tag,
    input  logic             src1_rdy,
    input  logic [TAG_W-1:0] src1_tag,
    input  logic [XLEN-1:0]  src1_val,
    input  logic             src2_rdy,
    input  logic [TAG_W-1:0] src2_tag,
    input  logic [XLEN-1:0]  src2_val,
    output logic             disp_ready,

    input  logic             alu_res_valid,
    input  logic [TAG_W-1:0] alu_res_tag,
    input  logic [XLEN-1:0]  alu_res_data,
    input  logic             mul_res_valid,
    input  logic [TAG_W-1:0] mul_res_tag,
    input  logic [XLEN-1:0]  mul_res_data,

    output logic             alu_issue,
    output op_e              alu_op,
    output logic [TAG_W-1:0] alu_tag,
    output logic [XLEN-1:0]  alu_a,
    output logic [XLEN-1:0]  alu_b,
    output logic             mul_issue,
    output logic [TAG_W-1:0] mul_tag,
    output logic [XLEN-1:0]  mul_a,
    output logic [XLEN-1:0]  mul_b
);

    // per-entry state
    logic [RS_DEPTH-1:0] ent_busy;     // slot between head and tail
    logic [RS_DEPTH-1:0] ent_issued;   // sent to a unit, waiting for head
    op_e                 ent_op  [RS_DEPTH];
    logic [TAG_W-1:0]    ent_tag [RS_DEPTH];
    logic [RS_DEPTH-1:0] s1_rdy;
    logic [RS_DEPTH-1:0] s2_rdy;
    logic [TAG_W-1:0]    s1_tag  [RS_DEPTH];
    logic [TAG_W-1:0]    s2_tag  [RS_DEPTH];
    logic [XLEN-1:0]     s1_val  [RS_DEPTH];
    logic [XLEN-1:0]     s2_val  [RS_DEPTH];

    logic [RS_IDX_W-1:0] head;
    logic [RS_IDX_W-1:0] tail;
    logic [RS_IDX_W:0]   count;        // occupied slots, holes included

    logic                disp_fire;
    logic                retire;
    logic                d1_rdy;
    logic                d2_rdy;
    logic [XLEN-1:0]     d1_val;
    logic [XLEN-1:0]     d2_val;
    logic                sel_found;
    logic [RS_IDX_W-1:0] sel_idx;

    // snoop both result buses for one pending source
    function automatic logic [XLEN:0] capture(
        input logic             rdy,
        input logic [TAG_W-1:0] tag,
        input logic [XLEN-1:0]  val
    );
        if (!rdy && alu_res_valid && (alu_res_tag == tag)) begin
            return {1'b1, alu_res_data};
        end
        if (!rdy && mul_res_valid && (mul_res_tag == tag)) begin
            return {1'b1, mul_res_data};
        end
        return {rdy, val};
    endfunction

    assign disp_ready = (count != (RS_IDX_W+1)'(RS_DEPTH));
    assign disp_fire  = disp_valid && disp_ready;
    assign retire     = ent_busy[head] && ent_issued[head];

    // bypass: tag broadcast in the dispatch cycle
    always_comb begin
        {d1_rdy, d1_val} = capture(src1_rdy, src1_tag, src1_val);
        {d2_rdy, d2_val} = capture(src2_rdy, src2_tag, src2_val);
    end

    // oldest ready entry, scanning from head
    always_comb begin
        logic [RS_IDX_W-1:0] idx;
        sel_found = 1'b0;
        sel_idx   = head;
        for (int k = 0; k < RS_DEPTH; k++) begin
            idx = head + RS_IDX_W'(k);
            if (!sel_found && ent_busy[idx] && !ent_issued[idx] && s1_rdy[idx] && s2_rdy[idx]) begin
                sel_found = 1'b1;
                sel_idx   = idx;
            end
        end
    end

    always_ff @(posedge rs_on) begin
        if (!rst_n) begin
            ent_busy   <= '0;
            ent_issued <= '0;
            head       <= '0;
            tail       <= '0;
            count      <= '0;
        end else begin
            if (disp_fire) begin
                ent_busy[tail]   <= 1'b1;
                ent_issued[tail] <= 1'b0;
                tail             <= tail + 1'b1;
            end
            if (sel_found) begin
                ent_issued[sel_idx] <= 1'b1;
            end
            if (retire) begin    // reclaim one hole per cycle
                ent_busy[head]   <= 1'b0;
                ent_issued[head] <= 1'b0;
                head             <= head + 1'b1;
            end
            count <= count + (RS_IDX_W+1)'(disp_fire) - (RS_IDX_W+1)'(retire);
        end
    end

    // entry payload, source fields and wakeup
    always_ff @(posedge rs_on) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (disp_fire && (tail == RS_IDX_W'(i))) begin
                ent_op[i]  <= disp_op;
                ent_tag[i] <= disp_tag;
                s1_tag[i]  <= src1_tag;
                s2_tag[i]  <= src2_tag;
                s1_rdy[i]  <= d1_rdy;
                s2_rdy[i]  <= d2_rdy;
                s1_val[i]  <= d1_val;
                s2_val[i]  <= d2_val;
            end else if (ent_busy[i]) begin
                {s1_rdy[i], s1_val[i]} <= capture(s1_rdy[i], s1_tag[i], s1_val[i]);
                {s2_rdy[i], s2_val[i]} <= capture(s2_rdy[i], s2_tag[i], s2_val[i]);
            end
        end
    end

    // route by opcode
    assign alu_issue = sel_found && (ent_op[sel_idx] != OP_MUL);
    assign mul_issue = sel_found && (ent_op[sel_idx] == OP_MUL);

    assign alu_op  = ent_op[sel_idx];
    assign alu_tag = ent_tag[sel_idx];
    assign alu_a   = s1_val[sel_idx];
    assign alu_b   = s2_val[sel_idx];
    assign mul_tag = ent_tag[sel_idx];
    assign mul_a   = s1_val[sel_idx];
    assign mul_b   = s2_val[sel_idx];

endmodule

//--- rtl/int_alu.sv
`timescale 1ns/1ps

module int_alu
    import ooo_pkg::*;
(
    input  logic             rs_on,
    input  logic             rst_n,
    input  logic             alu_issue,
    input  op_e              alu_op,
    input  logic [TAG_W-1:0] alu_tag,
    input  logic [XLEN-1:0]  alu_a,
    input  logic [XLEN-1:0]  alu_b,
    output logic             alu_res_valid,
    output logic [TAG_W-1:0] alu_res_tag,
    output logic [XLEN-1:0]  alu_res_data
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (alu_op)
            OP_ADD:  result = alu_a + alu_b;
            OP_SUB:  result = alu_a - alu_b;
            OP_AND:  result = alu_a & alu_b;
            OP_XOR:  result = alu_a ^ alu_b;
            default: result = '0;   // mul never routed here
        endcase
    end

    always_ff @(posedge rs_on) begin
        if (!rst_n) begin
            alu_res_valid <= 1'b0;
        end else begin
            alu_res_valid <= alu_issue;   // one-cycle pulse
        end
    end

    always_ff @(posedge rs_on) begin
        if (alu_issue) begin
            alu_res_tag  <= alu_tag;
            alu_res_data <= result;
        end
    end

endmodule

//--- rtl/mul_pipe.sv
`timescale 1ns/1ps

module mul_pipe
    import ooo_pkg::*;
(
    input  logic             rs_on,
    input  logic             rst_n,
    input  logic             mul_issue,
    input  logic [TAG_W-1:0] mul_tag,
    input  logic [XLEN-1:0]  mul_a,
    input  logic [XLEN-1:0]  mul_b,
    output logic             mul_res_valid,
    output logic [TAG_W-1:0] mul_res_tag,
    output logic [XLEN-1:0]  mul_res_data
);

    logic [MUL_STAGES-1:0] vld_q;
    logic [TAG_W-1:0]      tag_q [MUL_STAGES];

    // stage 1: 16-bit partial products
    logic [XLEN-1:0]   pp_ll_q;
    logic [XLEN/2-1:0] pp_hl_q;   // only low half reaches the result
    logic [XLEN/2-1:0] pp_lh_q;
    // stage 2: cross terms summed
    logic [XLEN-1:0]   pp_ll2_q;
    logic [XLEN/2-1:0] cross_q;
    // stage 3: final product, low word
    logic [XLEN-1:0]   prod_q;

    always_ff @(posedge rs_on) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MUL_STAGES-2:0], mul_issue};
        end
    end

    always_ff @(posedge rs_on) begin
        tag_q[0] <= mul_tag;
        for (int k = 1; k < MUL_STAGES; k++) begin
            tag_q[k] <= tag_q[k-1];
        end

        pp_ll_q  <= mul_a[XLEN/2-1:0] * mul_b[XLEN/2-1:0];
        pp_hl_q  <= mul_a[XLEN-1:XLEN/2] * mul_b[XLEN/2-1:0];
        pp_lh_q  <= mul_a[XLEN/2-1:0] * mul_b[XLEN-1:XLEN/2];

        pp_ll2_q <= pp_ll_q;
        cross_q  <= pp_hl_q + pp_lh_q;

        prod_q   <= pp_ll2_q + {cross_q, {(XLEN/2){1'b0}}};
    end

    assign mul_res_valid = vld_q[MUL_STAGES-1];
    assign mul_res_tag   = tag_q[MUL_STAGES-1];
    assign mul_res_data  = prod_q;

endmodule

//--- rtl/ooo_exec_top.sv
`timescale 1ns/1ps

module ooo_exec_top
    import ooo_pkg::*;
(
    input  logic             rs_on,
    input  logic             rst_n,
    input  logic             disp_valid,
    input  op_e              disp_op,
    input  logic [TAG_W-1:0] disp_tag,
    input  logic             src1_rdy,
    input  logic [TAG_W-1:0] src1_tag,
    input  logic [XLEN-1:0]  src1_val,
    input  logic             src2_rdy,
    input  logic [TAG_W-1:0] src2_tag,
    input  logic [XLEN-1:0]  src2_val,
    output logic             disp_ready,
    output logic             alu_res_valid,
    output logic [TAG_W-1:0] alu_res_tag,
    output logic [XLEN-1:0]  alu_res_data,
    output logic             mul_res_valid,
    output logic [TAG_W-1:0] mul_res_tag,
    output logic [XLEN-1:0]  mul_res_data
);

    // issue paths
    logic             alu_issue;
    op_e              alu_op;
    logic [TAG_W-1:0] alu_tag;
    logic [XLEN-1:0]  alu_a;
    logic [XLEN-1:0]  alu_b;
    logic             mul_issue;
    logic [TAG_W-1:0] mul_tag;
    logic [XLEN-1:0]  mul_a;
    logic [XLEN-1:0]  mul_b;

    reservation_station i_rs (
        .rs_on         (rs_on),
        .rst_n         (rst_n),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_tag      (disp_tag),
        .src1_rdy      (src1_rdy),
        .src1_tag      (src1_tag),
        .src1_val      (src1_val),
        .src2_rdy      (src2_rdy),
        .src2_tag      (src2_tag),
        .src2_val      (src2_val),
        .disp_ready    (disp_ready),
        .alu_res_valid (alu_res_valid),
        .alu_res_tag   (alu_res_tag),
        .alu_res_data  (alu_res_data),
        .mul_res_valid (mul_res_valid),
        .mul_res_tag   (mul_res_tag),
        .mul_res_data  (mul_res_data),
        .alu_issue     (alu_issue),
        .alu_op        (alu_op),
        .alu_tag       (alu_tag),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .mul_issue     (mul_issue),
        .mul_tag       (mul_tag),
        .mul_a         (mul_a),
        .mul_b         (mul_b)
    );

    int_alu i_alu (
        .rs_on         (rs_on),
        .rst_n         (rst_n),
        .alu_issue     (alu_issue),
        .alu_op        (alu_op),
        .alu_tag       (alu_tag),
        .alu_a         (alu_a),
        .alu_b         (alu_b),
        .alu_res_valid (alu_res_valid),
        .alu_res_tag   (alu_res_tag),
        .alu_res_data  (alu_res_data)
    );

    mul_pipe i_mul (
        .rs_on         (rs_on),
        .rst_n         (rst_n),
        .mul_issue     (mul_issue),
        .mul_tag       (mul_tag),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .mul_res_valid (mul_res_valid),
        .mul_res_tag   (mul_res_tag),
        .mul_res_data  (mul_res_data)
    );

endmodule

//--- tests/ooo_exec_props.sv
`timescale 1ns/1ps

module ooo_exec_props
    import ooo_pkg::*;
(
    input logic                rs_on,
    input logic                rst_n,
    input logic                disp_valid,
    input logic                disp_ready,
    input logic [RS_IDX_W-1:0] tail,
    input logic [RS_DEPTH-1:0] ent_busy,
    input logic                alu_issue,
    input logic                mul_issue,
    input logic                alu_res_valid,
    input logic                mul_res_valid
);

    a_single_issue: assert property (@(posedge rs_on) disable iff (!rst_n)
        !(alu_issue && mul_issue))
        else $error("alu and multiplier issued in the same cycle");

    // an accepted dispatch lands in a free slot
    a_no_fire_when_full: assert property (@(posedge rs_on) disable iff (!rst_n)
        (disp_valid && disp_ready) |-> !ent_busy[tail])
        else $error("dispatch accepted while the station was full");

    a_mul_latency: assert property (@(posedge rs_on) disable iff (!rst_n)
        $past(rst_n, MUL_STAGES) |-> (mul_res_valid == $past(mul_issue, MUL_STAGES)))
        else $error("mul_res_valid does not follow mul_issue by the pipeline depth");

    a_reset_quiet: assert property (@(posedge rs_on)
        !rst_n |=> (disp_ready && !alu_issue && !mul_issue && !alu_res_valid && !mul_res_valid))
        else $error("control outputs not idle after reset");

endmodule

bind reservation_station ooo_exec_props i_props (
    .rs_on         (rs_on),
    .rst_n         (rst_n),
    .disp_valid    (disp_valid),
    .disp_ready    (disp_ready),
    .tail          (tail),
    .ent_busy      (ent_busy),
    .alu_issue     (alu_issue),
    .mul_issue     (mul_issue),
    .alu_res_valid (alu_res_valid),
    .mul_res_valid (mul_res_valid)
);

//--- tests/ooo_exec_tb.sv
`timescale 1ns/1ps

module ooo_exec_tb
    import ooo_pkg::*;
();

    localparam int MAX_ROWS = 48;
    localparam int N_TAGS   = 1 << TAG_W;
    localparam int WAIT_MAX = 300;   // cycles allowed per wait loop

    logic             rs_on;
    logic             rst_n;
    logic             disp_valid;
    op_e              disp_op;
    logic [TAG_W-1:0] disp_tag;
    logic             src1_rdy;
    logic [TAG_W-1:0] src1_tag;
    logic [XLEN-1:0]  src1_val;
    logic             src2_rdy;
    logic [TAG_W-1:0] src2_tag;
    logic [XLEN-1:0]  src2_val;
    logic             disp_ready;
    logic             alu_res_valid;
    logic [TAG_W-1:0] alu_res_tag;
    logic [XLEN-1:0]  alu_res_data;
    logic             mul_res_valid;
    logic [TAG_W-1:0] mul_res_tag;
    logic [XLEN-1:0]  mul_res_data;

    // stimulus table; a source with ready 0 holds its producer row in the value column
    string            row_name [MAX_ROWS];
    op_e              row_op   [MAX_ROWS];
    logic [TAG_W-1:0] row_tag  [MAX_ROWS];
    bit               row_r1   [MAX_ROWS];
    bit               row_r2   [MAX_ROWS];
    logic [XLEN-1:0]  row_v1   [MAX_ROWS];
    logic [XLEN-1:0]  row_v2   [MAX_ROWS];
    int               row_gap  [MAX_ROWS];   // idle cycles before, -1 random
    logic [XLEN-1:0]  row_exp  [MAX_ROWS];
    int               n_rows;

    // scoreboard by tag
    int               tag_row  [N_TAGS];
    int               arr_cnt  [N_TAGS];
    logic [XLEN-1:0]  arr_data [N_TAGS];
    bit               saw_full;

    ooo_exec_top i_dut (
        .rs_on         (rs_on),
        .rst_n         (rst_n),
        .disp_valid    (disp_valid),
        .disp_op       (disp_op),
        .disp_tag      (disp_tag),
        .src1_rdy      (src1_rdy),
        .src1_tag      (src1_tag),
        .src1_val      (src1_val),
        .src2_rdy      (src2_rdy),
        .src2_tag      (src2_tag),
        .src2_val      (src2_val),
        .disp_ready    (disp_ready),
        .alu_res_valid (alu_res_valid),
        .alu_res_tag   (alu_res_tag),
        .alu_res_data  (alu_res_data),
        .mul_res_valid (mul_res_valid),
        .mul_res_tag   (mul_res_tag),
        .mul_res_data  (mul_res_data)
    );

    initial begin
        rs_on = 1'b0;
        forever #10 rs_on = ~rs_on;
    end

    function automatic logic [XLEN-1:0] model(input op_e op, input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            default: return a * b;   // low word of the product
        endcase
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
            $display("Errors found");
            $fatal(1, "check failed");
        end
    endtask

    task automatic add_row(input string name, input op_e op, input bit r1, input int v1,
                           input bit r2, input int v2, input int gap);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = r1 ? XLEN'(v1) : row_exp[v1];   // earlier row's result stands in for a tag
        b = r2 ? XLEN'(v2) : row_exp[v2];
        row_name[n_rows] = name;
        row_op[n_rows]   = op;
        row_tag[n_rows]  = TAG_W'(n_rows + 1);
        row_r1[n_rows]   = r1;
        row_r2[n_rows]   = r2;
        row_v1[n_rows]   = XLEN'(v1);
        row_v2[n_rows]   = XLEN'(v2);
        row_gap[n_rows]  = gap;
        row_exp[n_rows]  = model(op, a, b);
        tag_row[n_rows + 1] = n_rows;
        n_rows++;
    endtask

    task automatic build_table();
        int p;
        int q;
        // producer broadcasts in the dependent's dispatch cycle
        add_row("byp_alu_src", OP_ADD, 1, 5, 1, 7, 0);
        add_row("byp_alu_dep", OP_ADD, 0, 0, 1, 1, 1);
        add_row("byp_mul_src", OP_MUL, 1, 3, 1, 9, 1);
        add_row("byp_mul_dep", OP_XOR, 0, 2, 1, 32'h0000_00ff, 3);
        // one of each opcode
        add_row("ind_add", OP_ADD, 1, 32'h1234_5678, 1, 32'h1111_1111, -1);
        add_row("ind_sub", OP_SUB, 1, 32'h0000_0010, 1, 32'h0000_0020, -1);
        add_row("ind_and", OP_AND, 1, 32'hf0f0_1234, 1, 32'h0ff0_ffff, -1);
        add_row("ind_xor", OP_XOR, 1, 32'haaaa_5555, 1, 32'hffff_0000, -1);
        add_row("ind_mul", OP_MUL, 1, 32'h0001_2345, 1, 32'h0006_7890, -1);
        // mul -> add -> mul, then alu ops on the tail
        p = n_rows;
        add_row("chain_mul0", OP_MUL, 1, 32'hffff_fffd, 1, 7, -1);
        add_row("chain_add", OP_ADD, 0, p, 1, 100, -1);
        add_row("chain_mul1", OP_MUL, 0, p + 1, 0, p, -1);
        add_row("chain_sub", OP_SUB, 0, p + 2, 1, 5, -1);
        add_row("chain_xor", OP_XOR, 0, p + 3, 0, p + 1, -1);
        // back to back multiplies
        add_row("pipe_mul0", OP_MUL, 1, 32'h0000_ffff, 1, 32'h0001_0001, 0);
        add_row("pipe_mul1", OP_MUL, 1, 32'h8000_0001, 1, 3, 0);
        add_row("pipe_mul2", OP_MUL, 1, 32'h1357_9bdf, 1, 32'h2468_ace0, 0);
        add_row("pipe_mul3", OP_MUL, 1, 32'hdead_beef, 1, 32'hcafe_f00d, 0);
        // long chain, then a burst that waits on its end
        q = n_rows;
        add_row("long_mul0", OP_MUL, 1, 3, 1, 5, 0);
        for (int i = 1; i < 4; i++) begin
            add_row($sformatf("long_mul%0d", i), OP_MUL, 0, q + i - 1, 1, i + 2, 0);
        end
        for (int i = 0; i < 10; i++) begin
            add_row($sformatf("burst_%0d", i), OP_ADD, 0, q + 3, 1, i * 16, 0);
        end
    endtask

    // {ready, tag, value}; a finished producer is forwarded as a ready value
    function automatic logic [TAG_W+XLEN:0] src_field(input bit lit, input logic [XLEN-1:0] v);
        logic [TAG_W-1:0] ptag;
        if (lit) begin
            return {1'b1, {TAG_W{1'b0}}, v};
        end
        ptag = row_tag[int'(v)];
        if (arr_cnt[ptag] > 0) begin
            return {1'b1, ptag, arr_data[ptag]};
        end
        return {1'b0, ptag, {XLEN{1'b0}}};
    endfunction

    task automatic drive_row(input int r);
        disp_valid <= 1'b1;
        disp_op    <= row_op[r];
        disp_tag   <= row_tag[r];
        {src1_rdy, src1_tag, src1_val} <= src_field(row_r1[r], row_v1[r]);
        {src2_rdy, src2_tag, src2_val} <= src_field(row_r2[r], row_v2[r]);
    endtask

    task automatic dispatch(input int r);
        int waited;
        bit rdy_s;
        waited = 0;
        rdy_s  = 1'b0;
        drive_row(r);
        while (!rdy_s) begin
            @(negedge rs_on);
            rdy_s = disp_ready;
            @(posedge rs_on);
            if (!rdy_s) begin
                saw_full = 1'b1;
                waited++;
                if (waited > WAIT_MAX) begin
                    fail_now($sformatf("dispatch of %s never accepted", row_name[r]));
                end
                drive_row(r);   // sources may have completed meanwhile
            end
        end
    endtask

    task automatic idle(input int n);
        disp_valid <= 1'b0;
        repeat (n) @(posedge rs_on);
    endtask

    task automatic take_result(input logic [TAG_W-1:0] tag, input logic [XLEN-1:0] data,
                               input bit on_mul);
        int r;
        r = tag_row[tag];
        if (r < 0) begin
            fail_now($sformatf("result on tag %0d, which is not in the table", tag));
        end else begin
            arr_cnt[tag]++;
            arr_data[tag] = data;
            check({row_name[r], " count"}, 1, XLEN'(arr_cnt[tag]));
            check({row_name[r], " bus"}, XLEN'(row_op[r] == OP_MUL), XLEN'(on_mul));
            check(row_name[r], row_exp[r], data);
        end
    endtask

    // mid-cycle sampling of both result buses
    always @(negedge rs_on) begin
        if (rst_n) begin
            if (alu_res_valid) begin
                take_result(alu_res_tag, alu_res_data, 1'b0);
            end
            if (mul_res_valid) begin
                take_result(mul_res_tag, mul_res_data, 1'b1);
            end
        end
    end

    initial begin
        int wait_cnt;
        int gap;
        bit all_in;
        void'($urandom(96));
        rst_n      = 1'b0;
        disp_valid = 1'b0;
        disp_op    = OP_ADD;
        disp_tag   = '0;
        src1_rdy   = 1'b0;
        src1_tag   = '0;
        src1_val   = '0;
        src2_rdy   = 1'b0;
        src2_tag   = '0;
        src2_val   = '0;
        saw_full   = 1'b0;
        n_rows     = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            tag_row[t] = -1;
            arr_cnt[t] = 0;
        end
        build_table();

        repeat (2) @(posedge rs_on);
        rst_n <= 1'b1;
        repeat (3) begin   // idle after reset
            @(negedge rs_on);
            check("reset_disp_ready", 1, XLEN'(disp_ready));
            check("reset_alu_valid", 0, XLEN'(alu_res_valid));
            check("reset_mul_valid", 0, XLEN'(mul_res_valid));
        end
        @(posedge rs_on);

        for (int r = 0; r < n_rows; r++) begin
            gap = (row_gap[r] < 0) ? int'($urandom % 3) : row_gap[r];
            idle(gap);
            dispatch(r);
        end
        idle(0);

        wait_cnt = 0;
        all_in   = 1'b0;
        while (!all_in) begin
            @(posedge rs_on);
            all_in = 1'b1;
            for (int r = 0; r < n_rows; r++) begin
                if (arr_cnt[row_tag[r]] == 0) begin
                    all_in = 1'b0;
                end
            end
            wait_cnt++;
            if (wait_cnt > WAIT_MAX) begin
                fail_now("timed out waiting for every tag to return a result");
            end
        end
        repeat (6) @(posedge rs_on);   // room for a late duplicate
        check("station_filled", 1, XLEN'(saw_full));

        $display("No errors");
        $finish;
    end

endmodule

//--- filelist.f
rtl/ooo_pkg.sv
rtl/reservation_station.sv
rtl/int_alu.sv
rtl/mul_pipe.sv
rtl/ooo_exec_top.sv
tests/ooo_exec_props.sv
tests/ooo_exec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the out-of-order back end testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_exec_tb -f filelist.f -o ooo_exec_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/ooo_exec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
